// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= addrCoreTb
RTL_TOP   ?= addrCore
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
source/addrPkg.sv
source/opMemory.sv
source/addrSequencer.sv
source/opQueue.sv
source/groupOneExec.sv
source/addrCore.sv
verification/addrCoreTb.sv

// ==== source/addrCore.sv ====
`timescale 1ns/1ns

module addrCore (
    input  logic           CLK,
    input  logic           arstN,
    input  logic           run,         // Start fetching
    input  logic           loadEn,      // Host memory load
    input  addrPkg::addrT  loadAddr,
    input  addrPkg::byteT  loadData,
    input  logic           idxLoad,     // Strobe for X and Y
    input  addrPkg::byteT  idxX,
    input  addrPkg::byteT  idxY,
    output addrPkg::byteT  acc,
    output addrPkg::byteT  flags,
    output logic           retire,
    output addrPkg::opRecT retireRec,
    output logic           execWr,
    output addrPkg::addrT  execAddr,
    output addrPkg::byteT  execWdata
);

    addrPkg::addrT  fetchAddr;
    addrPkg::byteT  fetchData;
    addrPkg::byteT  execRdata;
    addrPkg::opRecT pushRec;
    addrPkg::opRecT popRec;
    logic           push;
    logic           pop;
    logic           full;
    logic           empty;

    // Shared memory, one port per side ----
    opMemory u_mem (
        .CLK       (CLK),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .fetchAddr (fetchAddr),
        .execAddr  (execAddr),
        .execWr    (execWr),
        .execWdata (execWdata),
        .fetchData (fetchData),
        .execRdata (execRdata)
    );

    // Producer
    addrSequencer u_seq (
        .CLK       (CLK),
        .arstN     (arstN),
        .run       (run),
        .idxLoad   (idxLoad),
        .idxX      (idxX),
        .idxY      (idxY),
        .fetchData (fetchData),
        .full      (full),
        .fetchAddr (fetchAddr),
        .push      (push),
        .pushRec   (pushRec)
    );

    opQueue u_queue (
        .CLK     (CLK),
        .arstN   (arstN),
        .push    (push),
        .pushRec (pushRec),
        .pop     (pop),
        .popRec  (popRec),
        .full    (full),
        .empty   (empty)
    );

    // Consumer
    groupOneExec u_exec (
        .CLK       (CLK),
        .arstN     (arstN),
        .empty     (empty),
        .popRec    (popRec),
        .execRdata (execRdata),
        .pop       (pop),
        .execAddr  (execAddr),
        .execWr    (execWr),
        .execWdata (execWdata),
        .acc       (acc),
        .flags     (flags),
        .retire    (retire),
        .retireRec (retireRec)
    );

endmodule

// ==== source/addrPkg.sv ====
package addrPkg;

    // Widths ---------------------------------
    typedef logic [7:0]  byteT;                 // Data byte
    typedef logic [15:0] addrT;                 // Bus address

    localparam addrT RESET_PC  = 16'h0200;      // First fetch after reset
    localparam int   MEM_BYTES = 65536;         // Whole 64 KiB space

    // Record queue sizing
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    typedef logic [QPTR_W-1:0] qPtrT;           // Queue slot index
    typedef logic [QPTR_W:0]   qCntT;           // Occupancy, one bit wider
    localparam qCntT QUEUE_FULL = qCntT'(QUEUE_DEPTH);

    // Operation field of group one, opcode bits 7..5
    typedef logic [2:0] opFieldT;
    localparam opFieldT OPC_ORA   = 3'b000;
    localparam opFieldT OPC_AND   = 3'b001;
    localparam opFieldT OPC_EOR   = 3'b010;
    localparam opFieldT OPC_ADC   = 3'b011;
    localparam opFieldT STORE_OPC = 3'b100;     // STA
    localparam opFieldT OPC_LDA   = 3'b101;
    localparam opFieldT OPC_CMP   = 3'b110;
    localparam opFieldT OPC_SBC   = 3'b111;

    // Status register bit positions
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_V = 6;
    localparam int FLAG_N = 7;

    // Types ----------------------------------
    typedef enum logic [3:0] {
        modeImm, modeZp, modeZpX, modeAbs, modeAbsX,
        modeAbsY, modeIndX, modeIndY, modeImp
    } addrModeE;

    typedef enum logic [2:0] {
        seqFetch,                               // Opcode byte
        seqOper,                                // First operand byte
        seqAbsHi,                               // High address byte
        seqPtrLo,                               // Zero-page pointer, low
        seqPtrHi,                               // Zero-page pointer, high
        seqLat                                  // Extra latency cycle
    } seqStateE;

    typedef struct packed {
        byteT     opcode;
        addrModeE mode;
        addrT     ea;                           // Effective address
        byteT     imm;                          // Immediate operand
    } opRecT;

endpackage

// ==== source/addrSequencer.sv ====
`timescale 1ns/1ns

module addrSequencer (
    input  logic           CLK,
    input  logic           arstN,
    input  logic           run,         // Sequencer enable
    input  logic           idxLoad,     // Strobe for X and Y
    input  addrPkg::byteT  idxX,
    input  addrPkg::byteT  idxY,
    input  addrPkg::byteT  fetchData,   // Async read of fetchAddr
    input  logic           full,        // Queue back-pressure
    output addrPkg::addrT  fetchAddr,
    output logic           push,
    output addrPkg::opRecT pushRec
);

    addrPkg::seqStateE state;
    addrPkg::seqStateE nextState;
    addrPkg::addrT     pc;              // Program counter
    addrPkg::addrT     ea;              // Pointer, then effective address
    addrPkg::byteT     opcode;          // Latched opcode
    addrPkg::addrModeE mode;            // Latched addressing mode
    addrPkg::addrModeE decMode;         // Mode of byte on the bus
    addrPkg::byteT     xReg;
    addrPkg::byteT     yReg;
    addrPkg::byteT     tr;              // Low address byte in flight
    logic              carry;           // Carry into high byte
    logic              isFinal;         // Record complete this cycle
    logic              advance;
    logic              useEa;           // Bus from ea instead of PC
    logic              incPc;
    logic              isStore;
    logic              lat;             // Needs the latency cycle
    logic [8:0]        xSum;
    logic [8:0]        ySum;
    addrPkg::byteT     hiSum;

    // Address arithmetic -------------------
    assign xSum    = {1'b0, fetchData} + {1'b0, xReg};
    assign ySum    = {1'b0, fetchData} + {1'b0, yReg};
    assign hiSum   = fetchData + {7'd0, carry};     // Page carry
    assign isStore = (opcode[7:5] == addrPkg::STORE_OPC);
    assign lat     = carry | isStore;

    assign useEa     = (state == addrPkg::seqPtrLo) || (state == addrPkg::seqPtrHi);
    assign incPc     = (state == addrPkg::seqFetch) || (state == addrPkg::seqOper)
                    || (state == addrPkg::seqAbsHi);
    assign fetchAddr = useEa ? ea : pc;

    assign advance = run && (!isFinal || !full);    // Hold while queue full
    assign push    = run && isFinal && !full;

    // Opcode decode, group one only
    always_comb begin
        if (fetchData[1:0] != 2'b01) begin
            decMode = addrPkg::modeImp;             // Runs as a NOP
        end else begin
            case (fetchData[4:2])
                3'b000:  decMode = addrPkg::modeIndX;
                3'b001:  decMode = addrPkg::modeZp;
                3'b010:  decMode = addrPkg::modeImm;
                3'b011:  decMode = addrPkg::modeAbs;
                3'b100:  decMode = addrPkg::modeIndY;
                3'b101:  decMode = addrPkg::modeZpX;
                3'b110:  decMode = addrPkg::modeAbsY;
                default: decMode = addrPkg::modeAbsX;
            endcase
        end
    end

    // Microsequence and record -------------
    always_comb begin
        nextState = state;
        isFinal   = 1'b0;
        pushRec   = '{opcode: opcode, mode: mode, ea: ea, imm: 8'h00};
        case (state)
            addrPkg::seqFetch: begin
                pushRec = '{opcode: fetchData, mode: decMode, ea: '0, imm: 8'h00};
                if (decMode == addrPkg::modeImp) begin
                    isFinal = 1'b1;                 // One-byte instruction
                end else begin
                    nextState = addrPkg::seqOper;
                end
            end
            addrPkg::seqOper: begin
                case (mode)
                    addrPkg::modeImm: begin
                        isFinal     = 1'b1;
                        pushRec.ea  = '0;
                        pushRec.imm = fetchData;
                    end
                    addrPkg::modeZp: begin
                        isFinal    = 1'b1;
                        pushRec.ea = {8'h00, fetchData};
                    end
                    addrPkg::modeZpX: nextState = addrPkg::seqLat;
                    addrPkg::modeIndX, addrPkg::modeIndY: nextState = addrPkg::seqPtrLo;
                    default: nextState = addrPkg::seqAbsHi;
                endcase
            end
            addrPkg::seqAbsHi: begin
                pushRec.ea = {hiSum, tr};
                if (mode == addrPkg::modeAbs || !lat) begin
                    isFinal = 1'b1;
                end else begin
                    nextState = addrPkg::seqLat;    // Page cross or STA
                end
            end
            addrPkg::seqPtrLo: nextState = addrPkg::seqPtrHi;
            addrPkg::seqPtrHi: begin
                pushRec.ea = {hiSum, tr};
                if (mode == addrPkg::modeIndY && !lat) begin
                    isFinal = 1'b1;
                end else begin
                    nextState = addrPkg::seqLat;    // Ind,X always waits
                end
            end
            default: isFinal = 1'b1;                // Latency cycle, ea ready
        endcase
        if (isFinal) begin
            nextState = addrPkg::seqFetch;
        end
    end

    // Control state
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state <= addrPkg::seqFetch;
            pc    <= addrPkg::RESET_PC;
            xReg  <= '0;
            yReg  <= '0;
        end else begin
            if (idxLoad) begin
                xReg <= idxX;
                yReg <= idxY;
            end
            if (advance) begin
                state <= nextState;
                if (incPc) begin
                    pc <= pc + 16'd1;
                end
            end
        end
    end

    // Address datapath ---------------------
    always_ff @(posedge CLK) begin
        if (advance) begin
            case (state)
                addrPkg::seqFetch: begin
                    opcode <= fetchData;
                    mode   <= decMode;
                end
                addrPkg::seqOper: begin
                    case (mode)
                        addrPkg::modeZpX, addrPkg::modeIndX: ea <= {8'h00, xSum[7:0]};
                        addrPkg::modeIndY: ea <= {8'h00, fetchData};
                        addrPkg::modeAbsX: {carry, tr} <= xSum;
                        addrPkg::modeAbsY: {carry, tr} <= ySum;
                        default:           {carry, tr} <= {1'b0, fetchData};
                    endcase
                end
                addrPkg::seqPtrLo: begin
                    ea[7:0] <= ea[7:0] + 8'd1;      // Wraps in page zero
                    if (mode == addrPkg::modeIndY) begin
                        {carry, tr} <= ySum;
                    end else begin
                        {carry, tr} <= {1'b0, fetchData};
                    end
                end
                addrPkg::seqAbsHi, addrPkg::seqPtrHi: ea <= {hiSum, tr};
                default: ;
            endcase
        end
    end

endmodule

// ==== source/groupOneExec.sv ====
`timescale 1ns/1ns

module groupOneExec (
    input  logic           CLK,
    input  logic           arstN,
    input  logic           empty,
    input  addrPkg::opRecT popRec,      // Queue head
    input  addrPkg::byteT  execRdata,
    output logic           pop,
    output addrPkg::addrT  execAddr,
    output logic           execWr,
    output addrPkg::byteT  execWdata,
    output addrPkg::byteT  acc,
    output addrPkg::byteT  flags,       // N V - - - - Z C
    output logic           retire,
    output addrPkg::opRecT retireRec
);

    addrPkg::opFieldT op;
    addrPkg::byteT    operand;
    addrPkg::byteT    addIn;            // Inverted for SBC and CMP
    addrPkg::byteT    aluRes;
    logic [8:0]       sum;
    logic             armed;            // Head seen last cycle
    logic             carryIn;
    logic             overflow;
    logic             isStore;
    logic             isArith;
    logic             doExec;

    assign op      = popRec.opcode[7:5];
    assign isStore = (op == addrPkg::STORE_OPC);
    assign isArith = (op == addrPkg::OPC_ADC) || (op == addrPkg::OPC_SBC);

    // Pop and retire together, a cycle after the head shows
    assign pop       = armed && !empty;
    assign retire    = pop;
    assign retireRec = popRec;
    assign doExec    = pop && (popRec.mode != addrPkg::modeImp);   // NOPs skip

    // Memory port
    assign execAddr  = popRec.ea;
    assign execWdata = acc;
    assign execWr    = doExec && isStore && (popRec.mode != addrPkg::modeImm);

    // ALU ----------------------------------
    assign operand  = (popRec.mode == addrPkg::modeImm) ? popRec.imm : execRdata;
    assign addIn    = (op == addrPkg::OPC_ADC) ? operand : ~operand;
    assign carryIn  = (op == addrPkg::OPC_CMP) ? 1'b1 : flags[addrPkg::FLAG_C];
    assign sum      = {1'b0, acc} + {1'b0, addIn} + {8'd0, carryIn};
    assign overflow = (acc[7] == addIn[7]) && (sum[7] != acc[7]);  // Sign flip

    always_comb begin
        case (op)
            addrPkg::OPC_ORA: aluRes = acc | operand;
            addrPkg::OPC_AND: aluRes = acc & operand;
            addrPkg::OPC_EOR: aluRes = acc ^ operand;
            addrPkg::OPC_LDA: aluRes = operand;
            addrPkg::STORE_OPC: aluRes = acc;
            default: aluRes = sum[7:0];     // ADC, SBC, CMP
        endcase
    end

    // Registers ----------------------------
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            armed <= 1'b0;
            acc   <= '0;
            flags <= '0;
        end else begin
            armed <= !empty && !pop;
            if (doExec && !isStore) begin
                if (op != addrPkg::OPC_CMP) begin
                    acc <= aluRes;          // CMP only compares
                end
                flags[addrPkg::FLAG_N] <= aluRes[7];
                flags[addrPkg::FLAG_Z] <= (aluRes == 8'h00);
                if (isArith || op == addrPkg::OPC_CMP) begin
                    flags[addrPkg::FLAG_C] <= sum[8];
                end
                if (isArith) begin
                    flags[addrPkg::FLAG_V] <= overflow;
                end
            end
        end
    end

endmodule

// ==== source/opMemory.sv ====
`timescale 1ns/1ns

module opMemory (
    input  logic          CLK,
    input  logic          loadEn,       // Host write, only while stopped
    input  addrPkg::addrT loadAddr,
    input  addrPkg::byteT loadData,
    input  addrPkg::addrT fetchAddr,    // Sequencer port
    input  addrPkg::addrT execAddr,     // Executor port
    input  logic          execWr,
    input  addrPkg::byteT execWdata,
    output addrPkg::byteT fetchData,
    output addrPkg::byteT execRdata
);

    addrPkg::byteT mem [addrPkg::MEM_BYTES];

    // Read ports ---------------------------
    assign fetchData = mem[fetchAddr];  // Same-cycle read
    assign execRdata = mem[execAddr];

    // Shared write port
    always_ff @(posedge CLK) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;  // Host has priority
        end else if (execWr) begin
            mem[execAddr] <= execWdata; // STA
        end
    end

endmodule

// ==== source/opQueue.sv ====
`timescale 1ns/1ns

module opQueue (
    input  logic           CLK,
    input  logic           arstN,
    input  logic           push,
    input  addrPkg::opRecT pushRec,
    input  logic           pop,
    output addrPkg::opRecT popRec,
    output logic           full,
    output logic           empty
);

    addrPkg::opRecT mem [addrPkg::QUEUE_DEPTH];
    addrPkg::qPtrT  rdPtr;
    addrPkg::qPtrT  wrPtr;
    addrPkg::qCntT  count;
    logic           doPush;
    logic           doPop;

    assign doPush = push && !full;      // Overflow dropped
    assign doPop  = pop && !empty;
    assign full   = (count == addrPkg::QUEUE_FULL);
    assign empty  = (count == '0);
    assign popRec = mem[rdPtr];         // Head visible without a pop

    // Pointers and occupancy ---------------
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + addrPkg::qPtrT'(1);
            end
            if (doPop) begin
                rdPtr <= rdPtr + addrPkg::qPtrT'(1);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + addrPkg::qCntT'(1);
                2'b01:   count <= count - addrPkg::qCntT'(1);
                default: ;                      // Both or neither
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (doPush) begin
            mem[wrPtr] <= pushRec;
        end
    end

endmodule

// ==== verification/addrCoreTb.sv ====
`timescale 1ns/1ns

module addrCoreTb;

    localparam int TAIL_NOPS = 16;          // Padding fetched after the last real op

    logic           CLK;
    logic           arstN;
    logic           run;
    logic           loadEn;
    addrPkg::addrT  loadAddr;
    addrPkg::byteT  loadData;
    logic           idxLoad;
    addrPkg::byteT  idxX;
    addrPkg::byteT  idxY;
    addrPkg::byteT  acc;
    addrPkg::byteT  flags;
    logic           retire;
    addrPkg::opRecT retireRec;
    logic           execWr;
    addrPkg::addrT  execAddr;
    addrPkg::byteT  execWdata;

    addrPkg::byteT  mMem [65536];           // Model memory image
    addrPkg::opRecT expQ [$];               // Expected records in program order
    addrPkg::opRecT cur;
    addrPkg::addrT  pc;
    addrPkg::byteT  xVal;
    addrPkg::byteT  yVal;
    addrPkg::byteT  mA;                     // Model accumulator
    addrPkg::byteT  mFlags;                 // Model status bits N V - - - - Z C
    int             seed;
    int             r;
    int             valueErrs;
    int             otherErrs;
    int             retired;
    int             progCount;
    int             cycles;
    int             limit;
    logic           pendChk;                // Acc check due next cycle
    logic           ranOnce;

    addrCore u_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Helpers ------------------------------
    task automatic reportValue(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        valueErrs++;
    endtask

    task automatic emit(input addrPkg::byteT b);
        mMem[pc] = b;
        pc = pc + 16'd1;
    endtask

    task automatic put2(input addrPkg::byteT op, input addrPkg::byteT b);
        emit(op);
        emit(b);
    endtask

    task automatic put3(input addrPkg::byteT op, input addrPkg::addrT a);
        emit(op);
        emit(a[7:0]);                       // Little endian
        emit(a[15:8]);
    endtask

    task automatic putImmRand(input addrPkg::byteT op);
        r = $random(seed);
        put2(op, r[7:0]);
    endtask

    // Decode by the 6502 group one rules
    function automatic addrPkg::opRecT decodeAt(input addrPkg::addrT at, output int len);
        addrPkg::opRecT rec;
        addrPkg::byteT  op;
        addrPkg::byteT  b;
        addrPkg::byteT  hi;
        addrPkg::byteT  p;
        addrPkg::addrT  base;
        op  = mMem[at];
        b   = mMem[at + 16'd1];
        hi  = mMem[at + 16'd2];
        rec = '{opcode: op, mode: addrPkg::modeImp, ea: '0, imm: '0};
        len = 1;
        if (op[1:0] == 2'b01) begin
            len = 2;
            case (op[4:2])
                3'd0: begin
                    p        = b + xVal;    // Pointer stays in page zero
                    rec.mode = addrPkg::modeIndX;
                    rec.ea   = {mMem[{8'h00, p + 8'd1}], mMem[{8'h00, p}]};
                end
                3'd1: begin
                    rec.mode = addrPkg::modeZp;
                    rec.ea   = {8'h00, b};
                end
                3'd2: begin
                    rec.mode = addrPkg::modeImm;
                    rec.imm  = b;
                end
                3'd3: begin
                    len      = 3;
                    rec.mode = addrPkg::modeAbs;
                    rec.ea   = {hi, b};
                end
                3'd4: begin
                    base     = {mMem[{8'h00, b + 8'd1}], mMem[{8'h00, b}]};
                    rec.mode = addrPkg::modeIndY;
                    rec.ea   = base + {8'h00, yVal};
                end
                3'd5: begin
                    rec.mode = addrPkg::modeZpX;
                    rec.ea   = {8'h00, b + xVal};   // Zero-page wrap
                end
                3'd6: begin
                    len      = 3;
                    rec.mode = addrPkg::modeAbsY;
                    rec.ea   = {hi, b} + {8'h00, yVal};
                end
                default: begin
                    len      = 3;
                    rec.mode = addrPkg::modeAbsX;
                    rec.ea   = {hi, b} + {8'h00, xVal};
                end
            endcase
        end
        return rec;
    endfunction

    // Reference execution of one retired record
    task automatic executeModel(input addrPkg::opRecT rec);
        addrPkg::byteT m;
        addrPkg::byteT m2;
        addrPkg::byteT res;
        logic [8:0]    s;
        logic [2:0]    f;
        f = rec.opcode[7:5];
        m = (rec.mode == addrPkg::modeImm) ? rec.imm : mMem[rec.ea];
        if (rec.mode == addrPkg::modeImp) begin
            res = mA;                       // NOP leaves A alone
        end else if (f == 3'b100) begin
            if (rec.mode != addrPkg::modeImm) begin
                assert (execWr && execAddr == rec.ea && execWdata == mA) else
                    reportValue($sformatf(
                        "STA wr=%b addr=%h data=%h, expected addr=%h data=%h",
                        execWr, execAddr, execWdata, rec.ea, mA));
                mMem[rec.ea] = mA;
            end
        end else begin
            m2 = (f == 3'b011) ? m : ~m;    // Subtract adds the complement
            s  = {1'b0, mA} + {1'b0, m2} + {8'd0, (f == 3'b110) ? 1'b1 : mFlags[0]};
            case (f)
                3'b000:  res = mA | m;
                3'b001:  res = mA & m;
                3'b010:  res = mA ^ m;
                3'b101:  res = m;
                default: res = s[7:0];
            endcase
            if (f == 3'b011 || f == 3'b111) begin
                mFlags[6] = (mA[7] == m2[7]) && (s[7] != mA[7]);
            end
            if (f == 3'b011 || f == 3'b111 || f == 3'b110) begin
                mFlags[0] = s[8];
            end
            mFlags[7] = res[7];
            mFlags[1] = (res == 8'h00);
            if (f != 3'b110) begin
                mA = res;                   // CMP keeps A
            end
        end
    endtask

    // Monitor ------------------------------
    always @(negedge CLK) begin
        if (!ranOnce) begin
            assert (!retire && !execWr) else
                reportValue("retire or execWr active before run");
        end
        if (pendChk) begin
            assert (acc == mA && flags == mFlags) else
                reportValue($sformatf(
                    "acc/flags %h/%h, expected %h/%h", acc, flags, mA, mFlags));
            pendChk = 1'b0;
        end
        if (retire) begin
            if (expQ.size() == 0) begin
                $display("Instruction retired after the model ran out of instructions");
                otherErrs++;
            end else begin
                cur = expQ.pop_front();
                assert (retireRec == cur) else
                    reportValue($sformatf(
                        "record #%0d op=%h mode=%0d ea=%h imm=%h, exp %h %0d %h %h",
                        retired, retireRec.opcode, retireRec.mode, retireRec.ea, retireRec.imm,
                        cur.opcode, cur.mode, cur.ea, cur.imm));
                retired++;
                executeModel(cur);
                pendChk = 1'b1;
            end
        end else begin
            assert (!execWr) else reportValue("execWr without retire");
        end
    end

    // Stimulus -----------------------------
    initial begin
        int len;
        addrPkg::addrT a;
        addrPkg::addrT progEnd;
        seed      = 32'h589a1ec4;
        arstN     = 1'b0;
        run       = 1'b0;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        idxLoad   = 1'b0;
        idxX      = '0;
        idxY      = '0;
        mA        = '0;
        mFlags    = '0;
        valueErrs = 0;
        otherErrs = 0;
        retired   = 0;
        cycles    = 0;
        pendChk   = 1'b0;
        ranOnce   = 1'b0;
        repeat (5) @(negedge CLK);
        arstN = 1'b1;

        r    = $random(seed);
        xVal = 8'h10 + {1'b0, r[6:0]};      // Crosses with low byte FF only
        r    = $random(seed);
        yVal = 8'h10 + {1'b0, r[6:0]};
        for (int i = 0; i < 65536; i++) begin
            mMem[i] = i[7:0] ^ i[15:8] ^ 8'h5A;
        end
        for (int i = 'h4000; i < 'h4600; i++) begin
            r       = $random(seed);
            mMem[i] = r[7:0];
        end
        for (int i = 'h80; i < 'hA0; i++) begin
            r       = $random(seed);
            mMem[i] = r[7:0];
        end
        mMem[16'h0020] = 8'h00;             // Pointers in page zero
        mMem[16'h0021] = 8'h41;
        mMem[16'h00FF] = 8'h80;
        mMem[16'h0000] = 8'h42;             // High byte after wrap
        mMem[16'h0030] = 8'h00;
        mMem[16'h0031] = 8'h43;
        mMem[16'h0032] = 8'hFF;
        mMem[16'h0033] = 8'h44;

        pc = addrPkg::RESET_PC;
        putImmRand(8'hA9);
        emit(8'hEA);
        putImmRand(8'h69);
        putImmRand(8'hE9);
        putImmRand(8'hC9);
        putImmRand(8'h09);
        putImmRand(8'h29);
        putImmRand(8'h49);
        put2(8'h05, 8'h84);
        emit(8'h02);
        put2(8'h65, 8'h88);
        put2(8'h35, 8'hF0);                 // ZP,X wraps
        put2(8'hF5, 8'h10);
        put3(8'h4D, 16'h4010);
        put3(8'h7D, 16'h4000);
        put3(8'hFD, 16'h40FF);              // Page cross
        put3(8'h19, 16'h4100);
        put3(8'hF9, 16'h41FF);
        put2(8'hA1, 8'h20 - xVal);
        put2(8'hC1, 8'hFF - xVal);          // Pointer high byte at 00
        put2(8'h11, 8'h30);
        put2(8'h71, 8'h32);
        put2(8'hD1, 8'hFF);
        putImmRand(8'hA9);
        put3(8'h8D, 16'h4520);
        put2(8'h85, 8'h90);
        put2(8'h95, 8'h60);
        put3(8'h9D, 16'h45FF);
        put3(8'h99, 16'h4500);
        put2(8'h81, 8'h20 - xVal);
        put2(8'h91, 8'h30);
        putImmRand(8'hA9);
        put3(8'hAD, 16'h4520);              // Read back the stores
        put2(8'hC5, 8'h90);
        put2(8'hB5, 8'h60);
        put2(8'hB1, 8'h30);
        put3(8'hBD, 16'h45FF);
        for (int i = 0; i < 12; i++) begin
            emit((i % 2 == 0) ? 8'hEA : 8'h1A);     // Fills the queue
        end
        put3(8'hDD, 16'h40FF);
        put2(8'hE1, 8'hFF - xVal);
        put2(8'h61, 8'h20 - xVal);
        put2(8'h55, 8'hF8);
        put3(8'h39, 16'h41F0);
        put3(8'h5D, 16'h4180);
        progEnd = pc;
        for (int i = 0; i < TAIL_NOPS; i++) begin
            emit(8'hEA);
        end

        a = addrPkg::RESET_PC;
        progCount = 0;
        while (a < pc) begin
            expQ.push_back(decodeAt(a, len));
            if (a < progEnd) begin
                progCount++;
            end
            a = a + addrPkg::addrT'(len);
        end

        for (int i = 0; i < 65536; i++) begin
            @(negedge CLK);
            loadEn   = 1'b1;
            loadAddr = addrPkg::addrT'(i);
            loadData = mMem[i];
        end
        @(negedge CLK);
        loadEn  = 1'b0;
        idxLoad = 1'b1;
        idxX    = xVal;
        idxY    = yVal;
        @(negedge CLK);
        idxLoad = 1'b0;
        repeat (3) @(negedge CLK);

        limit   = 40 * progCount + 100;
        run     = 1'b1;
        ranOnce = 1'b1;
        while (retired < progCount && cycles < limit) begin
            @(negedge CLK);
            cycles++;
        end
        run = 1'b0;
        if (retired < progCount) begin
            $display("Timeout: only %0d of %0d instructions retired", retired, progCount);
            otherErrs++;
        end
        repeat (30) @(negedge CLK);         // Let queued tail NOPs drain

        $display("Errors: value %0d, other %0d, retired %0d", valueErrs, otherErrs, retired);
        if (valueErrs + otherErrs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
